// File: rtl/cw_target_macros.svh
////////////////////////////////////////////////////////////////////////////
// Capture target constants
// Pin map, cipher rounds and JTAG identity
////////////////////////////////////////////////////////////////////////////

`ifndef CW_TARGET_MACROS_SVH
`define CW_TARGET_MACROS_SVH

// Pad counts
`define CW_NUM_MIO         20
`define CW_NUM_DIO         4

// Muxed pins used by the JTAG overlay and the trigger
`define CW_JTAG_EN_IDX     16
`define CW_JTAG_TRST_IDX   18
`define CW_TRIGGER_IDX     15

// Shared dedicated pins, SPI naming
`define CW_DIO_SCK_IDX     0
`define CW_DIO_CSB_IDX     1
`define CW_DIO_SDI_IDX     2
`define CW_DIO_SDO_IDX     3

`define CW_CIPHER_ROUNDS   16
`define CW_JTAG_IDCODE     32'h1a5c0c4d
`define CW_SPI_FRAME_BITS  40

`endif

// File: rtl/cw_target_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Capture target types
// SPI opcodes and the two views of the shared pins
////////////////////////////////////////////////////////////////////////////

package cw_target_pkg;

  // First byte of every SPI frame
  typedef enum logic [7:0] {
    OP_KEY   = 8'h01,
    OP_START = 8'h02,
    OP_GPIO  = 8'h03,
    OP_READ  = 8'h04
  } spi_op_e;

  // Bit 0 is SCK, bit 3 is SDO
  typedef struct packed {
    logic sdo;
    logic sdi;
    logic csb;
    logic sck;
  } spi_pins_t;

  // Same pin positions as the SPI view
  typedef struct packed {
    logic tdo;
    logic tdi;
    logic tms;
    logic tck;
  } jtag_pins_t;

  typedef union packed {
    spi_pins_t  spi;
    jtag_pins_t jtag;
  } dio_shared_u;

endpackage

// File: rtl/jtag_mux.sv
////////////////////////////////////////////////////////////////////////////
// JTAG overlay mux
// Shares the SPI pins with JTAG, selected by a strap on a muxed pin
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cw_target_macros.svh"

module jtag_mux (
  // Pad side
  input  logic [`CW_NUM_MIO-1:0]     mio_in_i,
  output logic [`CW_NUM_MIO-1:0]     mio_out_o,
  output logic [`CW_NUM_MIO-1:0]     mio_oe_o,
  input  cw_target_pkg::dio_shared_u dio_in_i,
  output cw_target_pkg::dio_shared_u dio_out_o,
  output cw_target_pkg::dio_shared_u dio_oe_o,
  // Core side
  output logic [`CW_NUM_MIO-1:0]     core_mio_in_o,
  input  logic [`CW_NUM_MIO-1:0]     core_mio_out_i,
  input  logic [`CW_NUM_MIO-1:0]     core_mio_oe_i,
  output cw_target_pkg::dio_shared_u core_dio_in_o,
  input  cw_target_pkg::dio_shared_u core_dio_out_i,
  input  cw_target_pkg::dio_shared_u core_dio_oe_i,
  // TAP side
  output logic                       jtag_tck_o,
  output logic                       jtag_tms_o,
  output logic                       jtag_tdi_o,
  output logic                       jtag_trst_no,
  input  logic                       jtag_tdo_i
);

  logic                   jtag_en;
  logic [`CW_NUM_MIO-1:0] jtag_pin_mask;

  assign jtag_en = mio_in_i[`CW_JTAG_EN_IDX];

  // Strap and TRST pins are owned by the overlay while JTAG is on
  always_comb begin
    jtag_pin_mask                    = '0;
    jtag_pin_mask[`CW_JTAG_EN_IDX]   = jtag_en;
    jtag_pin_mask[`CW_JTAG_TRST_IDX] = jtag_en;
  end

  assign core_mio_in_o = mio_in_i & ~jtag_pin_mask;
  assign mio_out_o     = core_mio_out_i & ~jtag_pin_mask;
  assign mio_oe_o      = core_mio_oe_i & ~jtag_pin_mask;

  // TAP pins stay idle and in reset while SPI owns the pins
  assign jtag_tck_o   = jtag_en & dio_in_i.jtag.tck;
  assign jtag_tms_o   = jtag_en & dio_in_i.jtag.tms;
  assign jtag_tdi_o   = jtag_en & dio_in_i.jtag.tdi;
  assign jtag_trst_no = jtag_en & mio_in_i[`CW_JTAG_TRST_IDX];

  always_comb begin
    if (jtag_en) begin
      // Core sees a deselected SPI bus
      core_dio_in_o         = '0;
      core_dio_in_o.spi.csb = 1'b1;
      dio_out_o             = '0;
      dio_out_o.jtag.tdo    = jtag_tdo_i;
      dio_oe_o              = '0;
      dio_oe_o.jtag.tdo     = 1'b1;
    end else begin
      core_dio_in_o = dio_in_i;
      dio_out_o     = core_dio_out_i;
      dio_oe_o      = core_dio_oe_i;
    end
  end

  // Only the SDO/TDO pin may ever be driven
  always_comb begin
    a_dio_oe_sdo_only: assert (!(dio_oe_o.spi.sck | dio_oe_o.spi.csb | dio_oe_o.spi.sdi))
      else $error("jtag_mux: output enable on an input-only shared pin");
  end

endmodule

// File: rtl/jtag_tap.sv
////////////////////////////////////////////////////////////////////////////
// Minimal JTAG TAP
// IEEE state machine with IDCODE and BYPASS data registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cw_target_macros.svh"

module jtag_tap (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o
);

  localparam logic [3:0] TLR    = 4'h0;
  localparam logic [3:0] RTI    = 4'h1;
  localparam logic [3:0] SEL_DR = 4'h2;
  localparam logic [3:0] CAP_DR = 4'h3;
  localparam logic [3:0] SH_DR  = 4'h4;
  localparam logic [3:0] EX1_DR = 4'h5;
  localparam logic [3:0] PA_DR  = 4'h6;
  localparam logic [3:0] EX2_DR = 4'h7;
  localparam logic [3:0] UPD_DR = 4'h8;
  localparam logic [3:0] SEL_IR = 4'h9;
  localparam logic [3:0] CAP_IR = 4'ha;
  localparam logic [3:0] SH_IR  = 4'hb;
  localparam logic [3:0] EX1_IR = 4'hc;
  localparam logic [3:0] PA_IR  = 4'hd;
  localparam logic [3:0] EX2_IR = 4'he;
  localparam logic [3:0] UPD_IR = 4'hf;

  // Any other instruction, 4'b1111 included, selects BYPASS
  localparam logic [3:0] IR_IDCODE = 4'b0001;

  logic [3:0]  state_q;
  logic [3:0]  state_d;
  logic [3:0]  ir_q;
  logic [3:0]  ir_sr_q;
  logic [31:0] idcode_sr_q;
  logic        bypass_q;

  always_comb begin
    case (state_q)
      TLR:     state_d = tms_i ? TLR    : RTI;
      RTI:     state_d = tms_i ? SEL_DR : RTI;
      SEL_DR:  state_d = tms_i ? SEL_IR : CAP_DR;
      CAP_DR:  state_d = tms_i ? EX1_DR : SH_DR;
      SH_DR:   state_d = tms_i ? EX1_DR : SH_DR;
      EX1_DR:  state_d = tms_i ? UPD_DR : PA_DR;
      PA_DR:   state_d = tms_i ? EX2_DR : PA_DR;
      EX2_DR:  state_d = tms_i ? UPD_DR : SH_DR;
      UPD_DR:  state_d = tms_i ? SEL_DR : RTI;
      SEL_IR:  state_d = tms_i ? TLR    : CAP_IR;
      CAP_IR:  state_d = tms_i ? EX1_IR : SH_IR;
      SH_IR:   state_d = tms_i ? EX1_IR : SH_IR;
      EX1_IR:  state_d = tms_i ? UPD_IR : PA_IR;
      PA_IR:   state_d = tms_i ? EX2_IR : PA_IR;
      EX2_IR:  state_d = tms_i ? UPD_IR : SH_IR;
      default: state_d = tms_i ? SEL_DR : RTI;
    endcase
  end

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q <= TLR;
      ir_q    <= IR_IDCODE;
    end else begin
      state_q <= state_d;
      if (state_q == TLR) begin
        ir_q <= IR_IDCODE;
      end else if (state_q == UPD_IR) begin
        ir_q <= ir_sr_q;
      end
    end
  end

  // Capture and shift stages, LSB out first
  always_ff @(posedge tck_i) begin
    case (state_q)
      CAP_IR: ir_sr_q <= 4'b0101;
      SH_IR:  ir_sr_q <= {tdi_i, ir_sr_q[3:1]};
      CAP_DR: begin
        idcode_sr_q <= `CW_JTAG_IDCODE;
        bypass_q    <= 1'b0;
      end
      SH_DR: begin
        idcode_sr_q <= {tdi_i, idcode_sr_q[31:1]};
        bypass_q    <= tdi_i;
      end
      default: ;
    endcase
  end

  // TDO retimed to the falling edge
  always_ff @(negedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      tdo_o <= 1'b0;
    end else if (state_q == SH_IR) begin
      tdo_o <= ir_sr_q[0];
    end else if (state_q == SH_DR) begin
      tdo_o <= (ir_q == IR_IDCODE) ? idcode_sr_q[0] : bypass_q;
    end else begin
      tdo_o <= 1'b0;
    end
  end

  a_trst_to_tlr: assert property (@(posedge tck_i) $fell(trst_ni) |=> state_q == TLR)
    else $error("jtag_tap: TRST did not reach Test-Logic-Reset");

endmodule

// File: rtl/spi_cmd_device.sv
////////////////////////////////////////////////////////////////////////////
// SPI command device
// Oversampled mode 0 slave decoding opcode and payload frames
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cw_target_macros.svh"

module spi_cmd_device (
  input  logic        clk_main_i,
  input  logic        rst_n_i,
  input  logic        sck_i,
  input  logic        csb_i,
  input  logic        sdi_i,
  output logic        sdo_o,
  output logic        sdo_oe_o,
  input  logic [31:0] result_i,
  output logic        key_we_o,
  output logic        start_o,
  output logic        gpio_we_o,
  output logic [31:0] payload_o
);

  localparam int OP_BITS = `CW_SPI_FRAME_BITS - 32;

  logic [2:0]                    sck_q;
  logic [2:0]                    csb_q;
  logic [1:0]                    sdi_q;
  logic                          sck_rise;
  logic                          sck_fall;
  logic                          csb_sync;
  logic                          csb_rise;
  logic [5:0]                    bit_cnt_q;
  logic [`CW_SPI_FRAME_BITS-1:0] frame_q;
  logic [31:0]                   rd_sr_q;
  logic                          rd_active_q;
  logic                          frame_done;
  logic                          op_is_read;
  cw_target_pkg::spi_op_e        cmd_op;

  // Two sync stages, the third flop only feeds edge detection
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign csb_sync = csb_q[1];
  assign csb_rise = csb_q[1] & ~csb_q[2];

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q     <= '0;
      csb_q     <= '1;
      sdi_q     <= '0;
      bit_cnt_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      csb_q <= {csb_q[1:0], csb_i};
      sdi_q <= {sdi_q[0], sdi_i};
      if (csb_sync) begin
        bit_cnt_q <= '0;
      end else if (sck_rise && bit_cnt_q != '1) begin
        bit_cnt_q <= bit_cnt_q + 6'd1;
      end
    end
  end

  // MSB first, opcode ends up in the top byte
  always_ff @(posedge clk_main_i) begin
    if (!csb_sync && sck_rise) begin
      frame_q <= {frame_q[`CW_SPI_FRAME_BITS-2:0], sdi_q[1]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame execution on CSB rise
  ////////////////////////////////////////////////////////////////////////////

  assign cmd_op     = cw_target_pkg::spi_op_e'(frame_q[`CW_SPI_FRAME_BITS-1 -: 8]);
  assign frame_done = csb_rise && (bit_cnt_q == 6'(`CW_SPI_FRAME_BITS));
  assign payload_o  = frame_q[31:0];

  assign key_we_o  = frame_done && (cmd_op == cw_target_pkg::OP_KEY);
  assign start_o   = frame_done && (cmd_op == cw_target_pkg::OP_START);
  assign gpio_we_o = frame_done && (cmd_op == cw_target_pkg::OP_GPIO);

  ////////////////////////////////////////////////////////////////////////////
  // Read data, updated after each SCK fall
  ////////////////////////////////////////////////////////////////////////////

  assign op_is_read = cw_target_pkg::spi_op_e'(frame_q[OP_BITS-1:0]) == cw_target_pkg::OP_READ;

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_active_q <= 1'b0;
    end else if (csb_sync) begin
      rd_active_q <= 1'b0;
    end else if (sck_fall && bit_cnt_q == 6'(OP_BITS) && op_is_read) begin
      rd_active_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (sck_fall) begin
      rd_sr_q <= (bit_cnt_q == 6'(OP_BITS)) ? result_i : {rd_sr_q[30:0], 1'b0};
    end
  end

  assign sdo_o    = rd_active_q & rd_sr_q[31];
  assign sdo_oe_o = rd_active_q;

  a_strobe_onehot: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    $onehot0({key_we_o, start_o, gpio_we_o}))
    else $error("spi_cmd_device: more than one write strobe");

endmodule

// File: rtl/round_engine.sv
////////////////////////////////////////////////////////////////////////////
// Round cipher engine
// Rotate and XOR rounds, one per clock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cw_target_macros.svh"

module round_engine (
  input  logic        clk_main_i,
  input  logic        rst_n_i,
  input  logic        key_we_i,
  input  logic        start_i,
  input  logic [31:0] payload_i,
  output logic        busy_o,
  output logic [31:0] result_o
);

  localparam int RW = $clog2(`CW_CIPHER_ROUNDS + 1);

  logic [31:0]   key_q;
  logic [31:0]   state_q;
  logic [RW-1:0] round_q;
  logic          busy_q;
  logic          launch;

  // A start during an encryption is dropped
  assign launch = start_i & ~busy_q;

  always_ff @(posedge clk_main_i) begin
    if (key_we_i) begin
      key_q <= payload_i;
    end
    if (launch) begin
      state_q <= payload_i;
    end else if (busy_q) begin
      state_q <= {state_q[28:0], state_q[31:29]} ^ key_q ^ 32'(round_q);
    end
  end

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      round_q <= '0;
      busy_q  <= 1'b0;
    end else if (launch) begin
      round_q <= '0;
      busy_q  <= 1'b1;
    end else if (busy_q) begin
      round_q <= round_q + 1'b1;
      busy_q  <= (round_q != RW'(`CW_CIPHER_ROUNDS - 1));
    end
  end

  assign busy_o   = busy_q;
  assign result_o = state_q;

  a_round_bound: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    round_q <= RW'(`CW_CIPHER_ROUNDS))
    else $error("round_engine: round counter out of range");

endmodule

// File: rtl/target_core.sv
////////////////////////////////////////////////////////////////////////////
// Capture target core
// GPIO registers, SPI command device, cipher engine and TAP
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cw_target_macros.svh"

module target_core (
  input  logic                       clk_main_i,
  input  logic                       rst_n_i,
  input  logic [`CW_NUM_MIO-1:0]     mio_in_i,
  output logic [`CW_NUM_MIO-1:0]     mio_out_o,
  output logic [`CW_NUM_MIO-1:0]     mio_oe_o,
  input  cw_target_pkg::dio_shared_u dio_in_i,
  output cw_target_pkg::dio_shared_u dio_out_o,
  output cw_target_pkg::dio_shared_u dio_oe_o,
  input  logic                       jtag_tck_i,
  input  logic                       jtag_tms_i,
  input  logic                       jtag_tdi_i,
  input  logic                       jtag_trst_ni,
  output logic                       jtag_tdo_o,
  output logic                       engine_busy_o
);

  logic [15:0] gpio_out_q;
  logic [15:0] gpio_oe_q;
  logic        key_we;
  logic        start;
  logic        gpio_we;
  logic [31:0] payload;
  logic [31:0] result;
  logic        sdo;
  logic        sdo_oe;

  // Low half drives values, high half drives enables
  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
    end else if (gpio_we) begin
      gpio_out_q <= payload[15:0];
      gpio_oe_q  <= payload[31:16];
    end
  end

  assign mio_out_o = {{(`CW_NUM_MIO-16){1'b0}}, gpio_out_q};
  assign mio_oe_o  = {{(`CW_NUM_MIO-16){1'b0}}, gpio_oe_q};

  // Core only ever drives SDO
  always_comb begin
    dio_out_o         = '0;
    dio_out_o.spi.sdo = sdo;
    dio_oe_o          = '0;
    dio_oe_o.spi.sdo  = sdo_oe;
  end

  spi_cmd_device u_spi (
    .clk_main_i ( clk_main_i       ),
    .rst_n_i    ( rst_n_i          ),
    .sck_i      ( dio_in_i.spi.sck ),
    .csb_i      ( dio_in_i.spi.csb ),
    .sdi_i      ( dio_in_i.spi.sdi ),
    .sdo_o      ( sdo              ),
    .sdo_oe_o   ( sdo_oe           ),
    .result_i   ( result           ),
    .key_we_o   ( key_we           ),
    .start_o    ( start            ),
    .gpio_we_o  ( gpio_we          ),
    .payload_o  ( payload          )
  );

  round_engine u_engine (
    .clk_main_i ( clk_main_i    ),
    .rst_n_i    ( rst_n_i       ),
    .key_we_i   ( key_we        ),
    .start_i    ( start         ),
    .payload_i  ( payload       ),
    .busy_o     ( engine_busy_o ),
    .result_o   ( result        )
  );

  // TAP has its own clock domain
  jtag_tap u_tap (
    .tck_i   ( jtag_tck_i   ),
    .trst_ni ( jtag_trst_ni ),
    .tms_i   ( jtag_tms_i   ),
    .tdi_i   ( jtag_tdi_i   ),
    .tdo_o   ( jtag_tdo_o   )
  );

endmodule

// File: rtl/cw_target_top.sv
////////////////////////////////////////////////////////////////////////////
// Capture target board top
// Reset sync, JTAG overlay, core and capture trigger gating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cw_target_macros.svh"

module cw_target_top (
  input  logic                   io_clk_i,
  input  logic                   rst_n_i,
  input  logic [`CW_NUM_MIO-1:0] mio_in_i,
  output logic [`CW_NUM_MIO-1:0] mio_out_o,
  output logic [`CW_NUM_MIO-1:0] mio_oe_o,
  input  logic [`CW_NUM_DIO-1:0] dio_in_i,
  output logic [`CW_NUM_DIO-1:0] dio_out_o,
  output logic [`CW_NUM_DIO-1:0] dio_oe_o,
  output logic                   tio_clkout_o
);

  logic                       clk_main;
  logic [1:0]                 rst_sync_q;
  logic                       rst_n;
  logic [`CW_NUM_MIO-1:0]     core_mio_in;
  logic [`CW_NUM_MIO-1:0]     core_mio_out;
  logic [`CW_NUM_MIO-1:0]     core_mio_oe;
  logic [`CW_NUM_MIO-1:0]     mio_out_gated;
  cw_target_pkg::dio_shared_u core_dio_in;
  cw_target_pkg::dio_shared_u core_dio_out;
  cw_target_pkg::dio_shared_u core_dio_oe;
  logic                       jtag_tck;
  logic                       jtag_tms;
  logic                       jtag_tdi;
  logic                       jtag_trst_n;
  logic                       jtag_tdo;
  logic                       engine_busy;

  assign clk_main = io_clk_i;

  // Asynchronous assert, synchronous release
  always_ff @(posedge clk_main or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // Overlay mux and core
  ////////////////////////////////////////////////////////////////////////////

  jtag_mux u_jtag_mux (
    .mio_in_i       ( mio_in_i      ),
    .mio_out_o      ( mio_out_o     ),
    .mio_oe_o       ( mio_oe_o      ),
    .dio_in_i       ( dio_in_i      ),
    .dio_out_o      ( dio_out_o     ),
    .dio_oe_o       ( dio_oe_o      ),
    .core_mio_in_o  ( core_mio_in   ),
    .core_mio_out_i ( mio_out_gated ),
    .core_mio_oe_i  ( core_mio_oe   ),
    .core_dio_in_o  ( core_dio_in   ),
    .core_dio_out_i ( core_dio_out  ),
    .core_dio_oe_i  ( core_dio_oe   ),
    .jtag_tck_o     ( jtag_tck      ),
    .jtag_tms_o     ( jtag_tms      ),
    .jtag_tdi_o     ( jtag_tdi      ),
    .jtag_trst_no   ( jtag_trst_n   ),
    .jtag_tdo_i     ( jtag_tdo      )
  );

  target_core u_core (
    .clk_main_i    ( clk_main     ),
    .rst_n_i       ( rst_n        ),
    .mio_in_i      ( core_mio_in  ),
    .mio_out_o     ( core_mio_out ),
    .mio_oe_o      ( core_mio_oe  ),
    .dio_in_i      ( core_dio_in  ),
    .dio_out_o     ( core_dio_out ),
    .dio_oe_o      ( core_dio_oe  ),
    .jtag_tck_i    ( jtag_tck     ),
    .jtag_tms_i    ( jtag_tms     ),
    .jtag_tdi_i    ( jtag_tdi     ),
    .jtag_trst_ni  ( jtag_trst_n  ),
    .jtag_tdo_o    ( jtag_tdo     ),
    .engine_busy_o ( engine_busy  )
  );

  // Trigger only reaches the pin while the cipher runs
  always_comb begin
    mio_out_gated                  = core_mio_out;
    mio_out_gated[`CW_TRIGGER_IDX] = core_mio_out[`CW_TRIGGER_IDX] & engine_busy;
  end

  // Clock forwarded to the capture board
  assign tio_clkout_o = io_clk_i;

endmodule

// File: tests/cw_target_tb.sv
////////////////////////////////////////////////////////////////////////////
// Capture target testbench
// SPI and JTAG pin drivers, cipher reference model and result checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cw_target_macros.svh"

module cw_target_tb;

  localparam int HALF_PERIOD = 50;
  localparam int PHASE_CLKS  = 4;
  localparam int ROUNDS      = `CW_CIPHER_ROUNDS;
  // JTAG shares the SPI pin positions
  localparam int TCK_BIT     = `CW_DIO_SCK_IDX;
  localparam int TMS_BIT     = `CW_DIO_CSB_IDX;
  localparam int TDI_BIT     = `CW_DIO_SDI_IDX;
  localparam int TDO_BIT     = `CW_DIO_SDO_IDX;

  logic                   clk;
  logic                   rst_n;
  logic [`CW_NUM_MIO-1:0] mio_in;
  logic [`CW_NUM_MIO-1:0] mio_out;
  logic [`CW_NUM_MIO-1:0] mio_oe;
  logic [`CW_NUM_DIO-1:0] dio_in;
  logic [`CW_NUM_DIO-1:0] dio_out;
  logic [`CW_NUM_DIO-1:0] dio_oe;
  logic                   clkout;
  logic                   trig_pin;

  logic [31:0] rng;
  logic [15:0] gpio_out_exp;
  logic [15:0] gpio_oe_exp;
  int          mismatches;
  int          timeouts;
  int          checks;
  int          trig_run;
  int          trig_pulses;
  string       name_q[$];
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];

  cw_target_top u_dut (
    .io_clk_i     ( clk     ),
    .rst_n_i      ( rst_n   ),
    .mio_in_i     ( mio_in  ),
    .mio_out_o    ( mio_out ),
    .mio_oe_o     ( mio_oe  ),
    .dio_in_i     ( dio_in  ),
    .dio_out_o    ( dio_out ),
    .dio_oe_o     ( dio_oe  ),
    .tio_clkout_o ( clkout  )
  );

  assign trig_pin = mio_out[`CW_TRIGGER_IDX] & mio_oe[`CW_TRIGGER_IDX];

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Rotate left by 3, then XOR key and round number
  function automatic logic [31:0] cipher_ref(input logic [31:0] key, input logic [31:0] data);
    logic [31:0] s;
    s = data;
    for (int r = 0; r < ROUNDS; r++) begin
      s = {s[28:0], s[31:29]} ^ key ^ 32'(r);
    end
    return s;
  endfunction

  task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Pin drivers
  ////////////////////////////////////////////////////////////////////////////

  // Mode 0 frame with SDO sampled just before each SCK rise
  task automatic spi_frame(input logic [7:0] op, input logic [31:0] data,
                           output logic [31:0] rdata);
    logic [`CW_SPI_FRAME_BITS-1:0] frame;
    frame = {op, data};
    rdata = '0;
    dio_in[`CW_DIO_CSB_IDX] = 1'b0;
    dio_in[`CW_DIO_SCK_IDX] = 1'b0;
    for (int i = `CW_SPI_FRAME_BITS - 1; i >= 0; i--) begin
      dio_in[`CW_DIO_SDI_IDX] = frame[i];
      wait_clocks(PHASE_CLKS);
      if (i < 32) begin
        rdata[i] = dio_out[`CW_DIO_SDO_IDX];
      end
      dio_in[`CW_DIO_SCK_IDX] = 1'b1;
      wait_clocks(PHASE_CLKS);
      dio_in[`CW_DIO_SCK_IDX] = 1'b0;
    end
    wait_clocks(PHASE_CLKS);
    dio_in[`CW_DIO_CSB_IDX] = 1'b1;
    dio_in[`CW_DIO_SDI_IDX] = 1'b0;
    wait_clocks(PHASE_CLKS);
  endtask

  // One TCK period with TDO sampled just before the rise
  task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
    dio_in[TMS_BIT] = tms;
    dio_in[TDI_BIT] = tdi;
    wait_clocks(PHASE_CLKS);
    tdo = dio_out[TDO_BIT];
    dio_in[TCK_BIT] = 1'b1;
    wait_clocks(PHASE_CLKS);
    dio_in[TCK_BIT] = 1'b0;
  endtask

  // LSB first with TMS high on the last bit to leave the shift state
  task automatic jtag_shift(input logic [31:0] tdi, input int nbits, output logic [31:0] tdo);
    logic bit_out;
    tdo = '0;
    for (int i = 0; i < nbits; i++) begin
      jtag_clock(i == nbits - 1, tdi[i], bit_out);
      tdo[i] = bit_out;
    end
  endtask

  task automatic program_gpio(input logic [31:0] word);
    logic [31:0] unused;
    spi_frame(cw_target_pkg::OP_GPIO, word, unused);
    gpio_out_exp = word[15:0];
    gpio_oe_exp  = word[31:16];
  endtask

  // Trigger bit reads 0 while the engine is idle
  task automatic check_gpio_idle(input string name);
    logic [15:0] out_exp;
    out_exp = gpio_out_exp;
    out_exp[`CW_TRIGGER_IDX] = 1'b0;
    expect_word({name, " gpio out"}, 32'(mio_out[15:0]), 32'(out_exp));
    expect_word({name, " gpio oe"}, 32'(mio_oe[15:0]), 32'(gpio_oe_exp));
  endtask

  task automatic wait_trigger_low(input int limit);
    int n;
    n = 0;
    while (trig_pin === 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (trig_pin === 1'b1) begin
      $display("Timeout at %0t: trigger pin still high after %0d clocks", $time, limit);
      timeouts++;
    end
  endtask

  task automatic drain_checks();
    int n;
    n = 0;
    while (name_q.size() > 0 && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (name_q.size() > 0) begin
      $display("Timeout at %0t: %0d checks were never compared", $time, name_q.size());
      timeouts++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Trigger monitor and comparing process
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (trig_pin === 1'b1) begin
      trig_run++;
    end else if (trig_run != 0) begin
      expect_word("trigger pulse length", 32'(trig_run), 32'(ROUNDS));
      trig_pulses++;
      trig_run = 0;
    end
  end

  always @(negedge clk) begin : compare_proc
    string       name;
    logic [31:0] got;
    logic [31:0] exp;
    while (name_q.size() > 0) begin
      name = name_q.pop_front();
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      checks++;
      if (got !== exp) begin
        $display("Mismatch at %0t: %s got %08h expected %08h", $time, name, got, exp);
        mismatches++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] key;
    logic [31:0] data;
    logic [31:0] rdata;
    logic [31:0] word;
    logic [31:0] tdi_word;
    logic [31:0] tdo_word;
    logic        tdo_bit;

    rng          = 32'ha50d4bc6;
    rst_n        = 1'b0;
    mio_in       = '0;
    dio_in       = '0;
    dio_in[`CW_DIO_CSB_IDX] = 1'b1;
    gpio_out_exp = '0;
    gpio_oe_exp  = '0;
    wait_clocks(16);
    rst_n = 1'b1;
    wait_clocks(4);

    expect_word("mio_oe after reset", 32'(mio_oe), 32'd0);
    expect_word("mio_out after reset", 32'(mio_out), 32'd0);
    expect_word("dio_oe after reset", 32'(dio_oe), 32'd0);

    // Forwarded clock follows the main clock
    #(HALF_PERIOD / 2);
    expect_word("clock out low", 32'(clkout), 32'd0);
    #HALF_PERIOD;
    expect_word("clock out high", 32'(clkout), 32'd1);
    @(negedge clk);

    // GPIO write with the trigger bit set but the engine idle
    rng  = xorshift32(rng);
    word = rng | 32'h0000_8000;
    program_gpio(word);
    check_gpio_idle("gpio write");
    expect_word("mio_out upper bits", 32'(mio_out[`CW_NUM_MIO-1:16]), 32'd0);

    // Encryptions with the trigger enabled
    rng = xorshift32(rng);
    program_gpio(rng | 32'h8000_8000);
    for (int n = 0; n < 8; n++) begin
      rng  = xorshift32(rng);
      key  = rng;
      rng  = xorshift32(rng);
      data = rng;
      spi_frame(cw_target_pkg::OP_KEY, key, rdata);
      spi_frame(cw_target_pkg::OP_START, data, rdata);
      wait_trigger_low(4 * ROUNDS);
      spi_frame(cw_target_pkg::OP_READ, 32'd0, rdata);
      expect_word("cipher result", rdata, cipher_ref(key, data));
    end
    wait_clocks(2);
    expect_word("trigger pulse count", 32'(trig_pulses), 32'd8);

    // Trigger value clear with the enable still set
    rng = xorshift32(rng);
    program_gpio((rng | 32'h8000_0000) & ~32'h0000_8000);
    rng  = xorshift32(rng);
    key  = rng;
    rng  = xorshift32(rng);
    data = rng;
    spi_frame(cw_target_pkg::OP_KEY, key, rdata);
    spi_frame(cw_target_pkg::OP_START, data, rdata);
    wait_clocks(2 * ROUNDS);
    spi_frame(cw_target_pkg::OP_READ, 32'd0, rdata);
    expect_word("cipher result, no trigger", rdata, cipher_ref(key, data));
    expect_word("trigger pulses with gpio 15 clear", 32'(trig_pulses), 32'd8);
    expect_word("trigger run with gpio 15 clear", 32'(trig_run), 32'd0);

    // Strap JTAG on and pulse TRST
    dio_in = '0;
    mio_in[`CW_JTAG_EN_IDX] = 1'b1;
    wait_clocks(PHASE_CLKS);
    mio_in[`CW_JTAG_TRST_IDX] = 1'b1;
    wait_clocks(PHASE_CLKS);
    expect_word("dio_oe in JTAG mode", 32'(dio_oe), 32'(1 << TDO_BIT));

    // IDCODE scan from Test-Logic-Reset
    jtag_clock(1'b0, 1'b0, tdo_bit);
    jtag_clock(1'b1, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);
    jtag_shift(32'd0, 32, tdo_word);
    expect_word("JTAG IDCODE", tdo_word, `CW_JTAG_IDCODE);
    jtag_clock(1'b1, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);

    // Load BYPASS through an IR scan
    jtag_clock(1'b1, 1'b0, tdo_bit);
    jtag_clock(1'b1, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);
    jtag_shift(32'hf, 4, tdo_word);
    jtag_clock(1'b1, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);

    // Bypass register delays TDI by one bit
    jtag_clock(1'b1, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);
    rng      = xorshift32(rng);
    tdi_word = rng & 32'h0000_ffff;
    jtag_shift(tdi_word, 16, tdo_word);
    expect_word("JTAG bypass", tdo_word, (tdi_word << 1) & 32'h0000_ffff);
    jtag_clock(1'b1, 1'b0, tdo_bit);
    jtag_clock(1'b0, 1'b0, tdo_bit);

    // SPI frames are blocked while JTAG owns the pins
    spi_frame(cw_target_pkg::OP_GPIO, ~{gpio_oe_exp, gpio_out_exp}, rdata);
    check_gpio_idle("gpio under JTAG");

    dio_in = '0;
    dio_in[`CW_DIO_CSB_IDX] = 1'b1;
    mio_in = '0;
    wait_clocks(PHASE_CLKS);
    drain_checks();

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: cw_target_top.f
+incdir+rtl
rtl/cw_target_pkg.sv
rtl/jtag_mux.sv
rtl/jtag_tap.sv
rtl/spi_cmd_device.sv
rtl/round_engine.sv
rtl/target_core.sv
rtl/cw_target_top.sv
tests/cw_target_tb.sv

// File: Makefile
# Verilator build and run for the capture target testbench

VERILATOR ?= verilator
TOP       ?= cw_target_tb
FLIST     ?= cw_target_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Status comes from the pass message in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
